//--- common/obj_pkg.sv
/*
  object side type definitions
  - object table entry and the scanner to draw engine request
  - scanner and draw engine FSM states
  - bounds of the visible horizontal window
*/
`default_nettype none

package obj_pkg;

    // attr holds vsub in 11..8, vflip in 6, hflip in 5 and palette in 4..0
    typedef struct packed {
        logic [15:0] code;      // tile code
        logic [8:0]  vpos;      // top line of the sprite
        logic [8:0]  hpos;      // left pixel of the sprite
        logic [15:0] attr;      // vsub ignored on entry
        logic [1:0]  bank;      // graphics ROM bank
    } obj_entry_t;

    typedef struct packed {
        logic [15:0] code;
        logic [15:0] attr;      // vsub holds the tile row
        logic [8:0]  hpos;
        logic [1:0]  bank;
    } obj_req_t;

    typedef enum logic [1:0] {
        S_IDLE,                 // waiting for the first line
        S_SCAN,                 // testing one entry per cycle
        S_WAIT_DRAW,            // object handed over
        S_DONE                  // line complete
    } scan_state_e;

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,                // waiting on rom_ok
        D_DRAW                  // eight pixel writes
    } draw_state_e;

    // object drawn only when hpos lies strictly inside
    localparam logic [8:0] HPOS_MIN = 9'h030;
    localparam logic [8:0] HPOS_MAX = 9'h1c0;

endpackage

`default_nettype wire

//--- common/mem_pkg.sv
/*
  memory side type definitions
  - graphics ROM request
  - line buffer write port
  - blank and transparent pixel values
*/
`default_nettype none

package mem_pkg;

    typedef struct packed {
        logic [19:0] addr;      // tile code then row
        logic [1:0]  bank;
        logic        half;      // which 32-bit word of the row
        logic        cs;
    } rom_req_t;

    typedef struct packed {
        logic [8:0] addr;       // horizontal position
        logic [8:0] data;       // palette then colour
        logic       we;         // one-cycle strobe
    } buf_wr_t;

    // value of a cleared line buffer location
    localparam logic [8:0] PXL_BLANK = 9'h1ff;

    // this colour never reaches the line buffer
    localparam logic [3:0] COLOUR_TRANSP = 4'd15;

endpackage

`default_nettype wire

//--- obj/obj_line_scan.sv
/*
  object table and line scanner
  - register array written by the host one entry per cycle
  - walks the table on line_start and finds objects covering the line
  - computes the tile row, applies vflip, hands each hit to the draw engine
*/
`default_nettype none

module obj_line_scan import obj_pkg::*; #(
    parameter int OBJ_COUNT = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0] tbl_addr,
    input  obj_entry_t                   tbl_entry,
    input  logic                         line_start,
    input  logic [8:0]                   line_num,
    input  logic                         idle,
    output obj_req_t                     req,
    output logic                         start,
    output logic                         scan_done
);

    localparam int IDX_W = $clog2(OBJ_COUNT);

    obj_entry_t       tbl [OBJ_COUNT];
    obj_entry_t       cur;
    scan_state_e      state;
    logic [IDX_W-1:0] idx;
    logic [8:0]       line_q;
    logic [8:0]       vdiff;
    logic [3:0]       row;
    logic             hit;
    logic             last_idx;
    logic             issue;

    assign cur      = tbl[idx];
    assign vdiff    = line_q - cur.vpos;            // wraps modulo 512
    assign hit      = vdiff[8:4] == 5'd0;           // 16 lines tall
    assign row      = cur.attr[6] ? ~vdiff[3:0] : vdiff[3:0];
    assign last_idx = idx == IDX_W'(OBJ_COUNT - 1);
    assign issue    = state == S_SCAN && !line_start && idle && hit;

    // table writes and the latched line number
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_entry;
        end
        if (line_start) begin
            line_q <= line_num;
        end
    end

    // request held stable until the next hit
    always_ff @(posedge clk) begin
        if (issue) begin
            req.code <= cur.code;
            req.attr <= {cur.attr[15:12], row, cur.attr[7:0]};
            req.hpos <= cur.hpos;
            req.bank <= cur.bank;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            idx       <= '0;
            start     <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            start <= 1'b0;
            if (line_start) begin
                state     <= S_SCAN;
                idx       <= '0;
                scan_done <= 1'b0;
            end else begin
                case (state)
                    S_SCAN: begin
                        if (issue) begin
                            start <= 1'b1;
                            state <= S_WAIT_DRAW;
                        end else if (idle) begin
                            if (last_idx) begin
                                state     <= S_DONE;
                                scan_done <= 1'b1;
                            end else begin
                                idx <= idx + 1'b1;
                            end
                        end
                    end
                    S_WAIT_DRAW: begin
                        // idle still high right after start means rejected
                        if (!start && idle) begin
                            if (last_idx) begin
                                state     <= S_DONE;
                                scan_done <= 1'b1;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= S_SCAN;
                            end
                        end
                    end
                    default: ;                       // S_IDLE and S_DONE hold
                endcase
            end
        end
    end

    // draw engine must never see a start while busy
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> idle
    );

endmodule

`default_nettype wire

//--- obj/obj_draw.sv
/*
  sprite draw engine for one tile row
  - fetches two 32-bit words of eight planar 4-bit pixels from graphics ROM
  - skips words that are fully transparent
  - applies hflip and writes palette and colour to the line buffer
*/
`default_nettype none

module obj_draw import obj_pkg::*; import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  obj_req_t    req,
    input  logic        start,
    output logic        idle,
    output buf_wr_t     wr,
    output rom_req_t    rom,
    input  logic [31:0] rom_data,
    input  logic        rom_ok
);

    draw_state_e state;
    logic [31:0] pxl;           // word being shifted out
    logic [8:0]  ptr;           // next line buffer position
    logic [4:0]  pal;
    logic        hflip;
    logic        second;        // current word is the second one
    logic        wait_cycle;
    logic [2:0]  pix_cnt;
    logic        rom_good;
    logic        in_window;

    assign idle      = state == D_IDLE;
    assign rom_good  = rom_ok && !wait_cycle;       // first rom_ok after a change is stale
    assign in_window = req.hpos > HPOS_MIN && req.hpos < HPOS_MAX;

    // one bit per byte makes up a pixel
    function automatic logic [3:0] colour(input logic [31:0] w, input logic flip);
        if (flip) begin
            return {w[24], w[16], w[8], w[0]};
        end
        return {w[31], w[23], w[15], w[7]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= D_IDLE;
            rom        <= '0;
            wr         <= '0;
            pxl        <= '0;
            ptr        <= '0;
            pal        <= '0;
            hflip      <= 1'b0;
            second     <= 1'b0;
            wait_cycle <= 1'b0;
            pix_cnt    <= '0;
        end else begin
            wait_cycle <= 1'b0;
            wr.we      <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start && in_window) begin
                        state      <= D_FETCH;
                        rom.cs     <= 1'b1;
                        rom.addr   <= {req.code, req.attr[11:8]};
                        rom.bank   <= req.bank;
                        rom.half   <= req.attr[5];      // right half first when flipped
                        pal        <= req.attr[4:0];
                        hflip      <= req.attr[5];
                        ptr        <= req.hpos;
                        second     <= 1'b0;
                        wait_cycle <= 1'b1;
                    end
                end
                D_FETCH: begin
                    if (rom_good) begin
                        pxl <= rom_data;
                        if (!second) begin
                            // prefetch the other half while drawing
                            rom.half   <= ~rom.half;
                            wait_cycle <= 1'b1;
                        end
                        if (&rom_data) begin
                            ptr <= ptr + 9'd8;          // all transparent
                            if (second) begin
                                state  <= D_IDLE;
                                rom.cs <= 1'b0;
                            end else begin
                                second <= 1'b1;
                            end
                        end else begin
                            state   <= D_DRAW;
                            pix_cnt <= '0;
                        end
                    end
                end
                D_DRAW: begin
                    wr.we   <= 1'b1;
                    wr.addr <= ptr;
                    wr.data <= {pal, colour(pxl, hflip)};
                    ptr     <= ptr + 9'd1;
                    pix_cnt <= pix_cnt + 3'd1;
                    pxl     <= hflip ? {1'b1, pxl[31:1]} : {pxl[30:0], 1'b1};
                    if (pix_cnt == 3'd7) begin
                        if (second) begin
                            state  <= D_IDLE;
                            rom.cs <= 1'b0;
                        end else begin
                            state  <= D_FETCH;
                            second <= 1'b1;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // writes come out of DRAW and land right of the window edge
    a_we_in_draw: assert property (
        @(posedge clk) disable iff (rst)
        wr.we |-> $past(state) == D_DRAW && wr.addr > HPOS_MIN
    );

    // ROM stays selected for the whole object
    a_cs_busy: assert property (
        @(posedge clk) disable iff (rst) state != D_IDLE |-> rom.cs
    );

endmodule

`default_nettype wire

//--- obj/obj_line_buffer.sv
/*
  double-buffered sprite line memory
  - two 512 x 9 banks, front for video and back for drawing
  - transparent pixels are dropped, reads clear the location
  - both banks blanked by a counter after reset
*/
`default_nettype none

module obj_line_buffer import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  buf_wr_t    wr,
    input  logic [8:0] pix_addr,
    output logic [8:0] pix_data
);

    logic [8:0] mem [2][512];
    logic       sel;            // front bank
    logic       clr_busy;
    logic [8:0] clr_cnt;
    logic       draw_ok;
    logic [1:0] bank_we;
    logic [8:0] bank_addr [2];
    logic [8:0] bank_din [2];

    assign draw_ok = wr.we && wr.data[3:0] != COLOUR_TRANSP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel      <= 1'b0;
            clr_busy <= 1'b1;
            clr_cnt  <= '0;
        end else begin
            if (line_start) begin
                sel <= ~sel;                        // swap front and back
            end
            if (clr_busy) begin
                clr_cnt <= clr_cnt + 9'd1;
                if (&clr_cnt) begin
                    clr_busy <= 1'b0;
                end
            end
        end
    end

    // front bank takes the clear-on-read, back bank takes the drawing
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (clr_busy) begin
                bank_we[b]   = 1'b1;
                bank_addr[b] = clr_cnt;
                bank_din[b]  = PXL_BLANK;
            end else if (1'(b) == sel) begin
                bank_we[b]   = 1'b1;
                bank_addr[b] = pix_addr;
                bank_din[b]  = PXL_BLANK;
            end else begin
                bank_we[b]   = draw_ok;
                bank_addr[b] = wr.addr;
                bank_din[b]  = wr.data;
            end
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk) begin
            if (bank_we[b]) begin
                mem[b][bank_addr[b]] <= bank_din[b];
            end
        end
    end

    // old value read on the same edge as its clear
    always_ff @(posedge clk) begin
        pix_data <= clr_busy ? PXL_BLANK : mem[sel][pix_addr];
    end

    // nothing may be drawing while the banks are blanked
    a_no_wr_in_clear: assert property (
        @(posedge clk) disable iff (rst) clr_busy |-> !wr.we
    );

endmodule

`default_nettype wire

//--- design/obj_engine_top.sv
/*
  sprite line renderer top level
  - object table and line scanner
  - ROM fetch and draw engine
  - double-buffered line buffer feeding video
*/
`default_nettype none

module obj_engine_top import obj_pkg::*; import mem_pkg::*; #(
    parameter int OBJ_COUNT = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    // host table port
    input  logic                         tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0] tbl_addr,
    input  obj_entry_t                   tbl_entry,
    // line control
    input  logic                         line_start,
    input  logic [8:0]                   line_num,
    output logic                         scan_done,
    // video readout
    input  logic [8:0]                   pix_addr,
    output logic [8:0]                   pix_data,
    // graphics ROM
    output rom_req_t                     rom,
    input  logic [31:0]                  rom_data,
    input  logic                         rom_ok
);

    obj_req_t req;
    logic     start;
    logic     idle;
    buf_wr_t  wr;

    obj_line_scan #(
        .OBJ_COUNT (OBJ_COUNT)
    ) u_scan (
        .clk        (clk),
        .rst        (rst),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_entry  (tbl_entry),
        .line_start (line_start),
        .line_num   (line_num),
        .idle       (idle),
        .req        (req),
        .start      (start),
        .scan_done  (scan_done)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .start    (start),
        .idle     (idle),
        .wr       (wr),
        .rom      (rom),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    obj_line_buffer u_buf (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr         (wr),
        .pix_addr   (pix_addr),
        .pix_data   (pix_data)
    );

endmodule

`default_nettype wire

//--- testbench/obj_rom_model.sv
/*
  graphics ROM model
  - content computed from address and half by a fixed rule
  - codes with low byte ff read as fully transparent
  - 1 to 4 cycles of latency drawn from a Galois LFSR
*/
`default_nettype none

module obj_rom_model import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  rom_req_t    rom,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h7101_d021;

    rom_req_t    last;          // request seen on the previous edge
    logic [1:0]  wait_cnt;
    logic [31:0] lfsr;
    logic [31:0] lfsr_1;
    logic [31:0] lfsr_2;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [31:0] word_at(input logic [19:0] a, input logic h);
        if (a[11:4] == 8'hff) begin
            return '1;                          // blank tile
        end
        return (32'(a) * 32'h9e37_79b1) ^ (h ? 32'h5a5a_5a5a : 32'h0);
    endfunction

    assign lfsr_1 = lfsr_step(lfsr);
    assign lfsr_2 = lfsr_step(lfsr_1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last     <= '0;
            wait_cnt <= 2'd0;
            lfsr     <= SEED;
            rom_ok   <= 1'b0;
            rom_data <= '0;
        end else if (rom != last) begin
            // restart the latency on a new request
            last     <= rom;
            rom_ok   <= 1'b0;
            wait_cnt <= {lfsr[0], lfsr_1[0]};   // one step per bit
            lfsr     <= lfsr_2;
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (rom.cs) begin
            rom_ok   <= 1'b1;
            rom_data <= word_at(rom.addr, rom.half);
        end
    end

endmodule

`default_nettype wire

//--- testbench/obj_engine_tb.sv
/*
  testbench for the sprite line renderer
  - table of object sets and line numbers, applied in a loop
  - reference line built from the placement and ROM rules
  - pixel readout checks, clear-on-read check, ROM bank check, cycle limit
*/
`default_nettype none

module obj_engine_tb import obj_pkg::*; import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int OBJ_COUNT  = 16;
    localparam int NUM_TESTS  = 6;
    localparam int RST_CYCLES = 10;
    localparam int CLR_CYCLES = 520;            // line buffer blanking after reset
    localparam int MAX_CYCLES = NUM_TESTS * 3000 + RST_CYCLES + CLR_CYCLES;

    typedef struct {
        string      name;
        logic [8:0] line;
        int         count;
        obj_entry_t obj [4];
    } test_row_t;

    logic        clk;
    logic        rst;
    logic        tbl_we;
    logic [3:0]  tbl_addr;
    obj_entry_t  tbl_entry;
    logic        line_start;
    logic [8:0]  line_num;
    logic        scan_done;
    logic [8:0]  pix_addr;
    logic [8:0]  pix_data;
    rom_req_t    rom;
    logic [31:0] rom_data;
    logic        rom_ok;

    test_row_t   tests [NUM_TESTS];
    logic [8:0]  model_line [512];
    int          cycles = 0;
    int          pixel_errors = 0;
    int          clear_errors = 0;
    int          rom_errors = 0;

    obj_engine_top #(
        .OBJ_COUNT (OBJ_COUNT)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_entry  (tbl_entry),
        .line_start (line_start),
        .line_num   (line_num),
        .scan_done  (scan_done),
        .pix_addr   (pix_addr),
        .pix_data   (pix_data),
        .rom        (rom),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok)
    );

    obj_rom_model u_rom (
        .clk      (clk),
        .rst      (rst),
        .rom      (rom),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, scan_done or readout never finished", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // bank a tile code is stored in
    function automatic logic [1:0] bank_of(input logic [15:0] code);
        return code[1:0];
    endfunction

    // each ROM request must carry the bank of its tile code
    always @(negedge clk) begin
        if (rom.cs && rom.bank !== bank_of(rom.addr[19:4])) begin
            $display("FAILED at %0d ns: rom.bank expected %h, got %h",
                     $time, bank_of(rom.addr[19:4]), rom.bank);
            rom_errors++;
        end
    end

    function automatic obj_entry_t make_obj(input logic [15:0] code, input logic [8:0] vpos,
                                            input logic [8:0] hpos, input logic [15:0] attr);
        obj_entry_t o;
        o.code = code;
        o.vpos = vpos;
        o.hpos = hpos;
        o.attr = attr;
        o.bank = bank_of(code);
        return o;
    endfunction

    // word contents by the same rule as the ROM
    function automatic logic [31:0] rom_word(input logic [19:0] a, input logic h);
        if (a[11:4] == 8'hff) begin
            return '1;
        end
        return (32'(a) * 32'h9e37_79b1) ^ (h ? 32'h5a5a_5a5a : 32'h0);
    endfunction

    // pixel k takes one bit from each byte with the top byte first
    function automatic logic [3:0] pixel_colour(input logic [31:0] w, input int k,
                                                input logic flip);
        int b;
        b = flip ? k : 7 - k;
        return {w[24 + b], w[16 + b], w[8 + b], w[b]};
    endfunction

    task automatic set_row(input int t, input string name, input logic [8:0] line,
                           input int count);
        tests[t].name  = name;
        tests[t].line  = line;
        tests[t].count = count;
    endtask

    task automatic fill_tests();
        set_row(0, "empty", 9'h080, 0);
        set_row(1, "single_window", 9'h080, 4);
        tests[1].obj[0] = make_obj(16'h0123, 9'h07b, 9'h031, 16'h0f03);  // junk vsub
        tests[1].obj[1] = make_obj(16'h0124, 9'h07b, 9'h030, 16'h0004);  // on left bound
        tests[1].obj[2] = make_obj(16'h0125, 9'h07b, 9'h1c0, 16'h0005);  // on right bound
        tests[1].obj[3] = make_obj(16'h0126, 9'h078, 9'h1bf, 16'h0006);
        set_row(2, "hflip", 9'h080, 2);
        tests[2].obj[0] = make_obj(16'h0321, 9'h07d, 9'h060, 16'h0009);
        tests[2].obj[1] = make_obj(16'h0321, 9'h07d, 9'h0a0, 16'h0029);
        set_row(3, "vflip_range", 9'h100, 4);
        tests[3].obj[0] = make_obj(16'h0222, 9'h0fd, 9'h040, 16'h000a);  // row 3
        tests[3].obj[1] = make_obj(16'h0222, 9'h0fd, 9'h080, 16'h004a);  // row 12
        tests[3].obj[2] = make_obj(16'h0333, 9'h0f0, 9'h0c0, 16'h000b);  // 16 away
        tests[3].obj[3] = make_obj(16'h0334, 9'h0f1, 9'h0e0, 16'h000c);  // last row
        set_row(4, "overlap", 9'h0c0, 4);
        tests[4].obj[0] = make_obj(16'h0111, 9'h0b8, 9'h070, 16'h0001);
        tests[4].obj[1] = make_obj(16'h0222, 9'h0bc, 9'h074, 16'h0002);
        tests[4].obj[2] = make_obj(16'h01ff, 9'h0b8, 9'h070, 16'h0003);  // blank tile
        tests[4].obj[3] = make_obj(16'h0333, 9'h0bf, 9'h078, 16'h0064);
        set_row(5, "vertical_wrap", 9'h005, 2);
        tests[5].obj[0] = make_obj(16'h0abc, 9'h1fa, 9'h100, 16'h0007);
        tests[5].obj[1] = make_obj(16'h0def, 9'h006, 9'h120, 16'h0008);  // one line below
    endtask

    // expected line with objects drawn in table order
    task automatic build_model(input int t);
        obj_entry_t o;
        logic [8:0]  diff;
        logic [3:0]  row;
        logic [31:0] w;
        logic [3:0]  c;
        for (int a = 0; a < 512; a++) begin
            model_line[a] = PXL_BLANK;
        end
        for (int n = 0; n < tests[t].count; n++) begin
            o    = tests[t].obj[n];
            diff = tests[t].line - o.vpos;
            if (diff < 9'd16 && o.hpos > HPOS_MIN && o.hpos < HPOS_MAX) begin
                row = o.attr[6] ? 4'd15 - diff[3:0] : diff[3:0];
                for (int h = 0; h < 2; h++) begin
                    w = rom_word({o.code, row}, 1'(h) ^ o.attr[5]);  // flip swaps halves
                    for (int k = 0; k < 8; k++) begin
                        c = pixel_colour(w, k, o.attr[5]);
                        if (c != COLOUR_TRANSP) begin
                            model_line[o.hpos + 9'(8 * h + k)] = {o.attr[4:0], c};
                        end
                    end
                end
            end
        end
    endtask

    task automatic write_entry(input int i, input obj_entry_t e);
        @(negedge clk);
        tbl_we    = 1'b1;
        tbl_addr  = 4'(i);
        tbl_entry = e;
    endtask

    task automatic load_table(input int t);
        for (int i = 0; i < OBJ_COUNT; i++) begin
            write_entry(i, make_obj(16'h0000, tests[t].line + 9'h100, 9'h000, 16'h0000));
        end
        for (int i = 0; i < tests[t].count; i++) begin
            write_entry(i, tests[t].obj[i]);
        end
        @(negedge clk);
        tbl_we = 1'b0;
    endtask

    task automatic start_line(input logic [8:0] line);
        @(negedge clk);
        line_start = 1'b1;
        line_num   = line;
        @(negedge clk);
        line_start = 1'b0;
        while (!scan_done) begin
            @(negedge clk);
        end
    endtask

    // data trails the address by one cycle in this pipelined readout
    task automatic read_line(input int t, input logic again);
        logic [8:0] exp_val;
        for (int a = 0; a <= 512; a++) begin
            @(negedge clk);
            if (a > 0) begin
                exp_val = again ? PXL_BLANK : model_line[a - 1];
                if (pix_data !== exp_val) begin
                    $display("FAILED at %0d ns: %s pix_data[%0d] expected %h, got %h",
                             $time, tests[t].name, a - 1, exp_val, pix_data);
                    if (again) begin
                        clear_errors++;
                    end else begin
                        pixel_errors++;
                    end
                end
            end
            if (a < 512) begin
                pix_addr = 9'(a);
            end
        end
        pix_addr = 9'h000;                      // no sprite reaches pixel 0
    endtask

    initial begin
        rst        = 1'b1;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_entry  = '0;
        line_start = 1'b0;
        line_num   = '0;
        pix_addr   = '0;
        fill_tests();
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (CLR_CYCLES) @(negedge clk);     // wait out the buffer clear
        for (int t = 0; t < NUM_TESTS; t++) begin
            $display("running %s", tests[t].name);
            load_table(t);
            build_model(t);
            start_line(tests[t].line);          // draw into the back half
            start_line(tests[t].line);          // swap it to the front
            read_line(t, 1'b0);
            read_line(t, 1'b1);                 // cleared by the first pass
        end
        $display("%0d pixel errors, %0d clear-on-read errors, %0d rom bank errors",
                 pixel_errors, clear_errors, rom_errors);
        if (pixel_errors == 0 && clear_errors == 0 && rom_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
common/obj_pkg.sv
common/mem_pkg.sv
obj/obj_line_scan.sv
obj/obj_draw.sv
obj/obj_line_buffer.sv
design/obj_engine_top.sv
testbench/obj_rom_model.sv
testbench/obj_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sprite line renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f project.f \
    --top-module obj_engine_tb \
    -Mdir obj_dir -o sim_obj

./obj_dir/sim_obj | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
